// File: klFrontEnd.f
hdl/klFePkg.sv
hdl/sixbitWordDecoder.sv
hdl/loadRecordParser.sv
hdl/cramWriter.sv
hdl/resetSequencer.sv
hdl/diagBusDriver.sv
hdl/klFrontEnd.sv
bench/klFrontEnd_assert.sv
bench/tbKlFrontEnd.sv

// File: Makefile
# Verilator build and run of the KL10 front-end loader testbench
VERILATOR ?= verilator
TOP       ?= tbKlFrontEnd
FILELIST  ?= klFrontEnd.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tbKlFrontEnd.sv
// tbKlFrontEnd: random load file stimulus against a reference model of the diagnostic bus
`timescale 1ns/1ns

module tbKlFrontEnd;

  logic              clk;
  logic              rstN;
  logic              charValid;
  logic [6:0]        charData;
  logic              charReady;
  klFePkg::diagFuncE diagFunc;
  logic              diagStrobe;
  logic [35:0]       ebusData;
  logic              ebusDriving;
  logic              cksumError;

  // Generated load file and expected bus operations
  logic [15:0]       lfsr = 16'd60;
  logic [6:0]        chars [$];
  int                lineEnds [$];
  bit                lineBad [$];
  logic [15:0]       fieldQ [$];
  klFePkg::diagFuncE expFunc [$];
  logic [35:0]       expData [$];
  bit                expDrv [$];
  logic [15:0]       lastAdr = '0;
  int                lineCount = 24;
  int                cksumSeen = 0;
  int                opsSeen = 0;
  int                curTest = 0;
  int                errCnt [3] = '{0, 0, 0};
  int                chkCnt [3] = '{0, 0, 0};
  bit                strobePrev = 1'b0;
  bit                genDone = 1'b0;

  klFrontEnd i_dut (
    .clk(clk), .rstN(rstN), .charValid(charValid), .charData(charData),
    .charReady(charReady), .diagFunc(diagFunc), .diagStrobe(diagStrobe),
    .ebusData(ebusData), .ebusDriving(ebusDriving), .cksumError(cksumError)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic int randBits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsrNext(lfsr);
    end
    return v;
  endfunction

  // Six-bit group to a character, either form when both are legal
  function automatic logic [6:0] asciiize(input logic [5:0] g);
    // Plain form must not be a space, comma or control char
    if (g > 6'o40 && g != 6'o54 && randBits(1) == 1) begin
      return {1'b0, g};
    end
    return {1'b1, g};
  endfunction

  ////////////////////////////////////////
  // Load file and model
  ////////////////////////////////////////

  // Leading zero groups dropped, zero is an empty field
  task automatic putField(input logic [15:0] v);
    if (v >= 16'd4096) chars.push_back(asciiize({2'b00, v[15:12]}));
    if (v >= 16'd64) chars.push_back(asciiize(v[11:6]));
    if (v != 16'd0) chars.push_back(asciiize(v[5:0]));
  endtask

  task automatic putLine(input logic [6:0] rec);
    chars.push_back(rec);
    chars.push_back(7'h20);
    foreach (fieldQ[i]) begin
      putField(fieldQ[i]);
      if (i < fieldQ.size() - 1) chars.push_back(7'h2c);
    end
    // CR gives one more empty field before LF
    chars.push_back(7'h0d);
    chars.push_back(7'h0a);
    lineEnds.push_back(chars.size());
    fieldQ.delete();
  endtask

  task automatic expectOp(input klFePkg::diagFuncE f, input logic [35:0] d, input bit drv);
    expFunc.push_back(f);
    expData.push_back(d);
    expDrv.push_back(drv);
  endtask

  task automatic expectResetTable();
    klFePkg::diagFuncE tbl [17];
    int i;
    tbl = '{klFePkg::CLR_RUN, klFePkg::CLK_SRC_RATE, klFePkg::STOP_CLOCK, klFePkg::SET_RESET,
      klFePkg::RESET_PAR_REGS, klFePkg::MBOXDIS_PARCHK_ERRSTOP, klFePkg::BURST_CTR_RH,
      klFePkg::BURST_CTR_LH, klFePkg::SET_EBOX_CLK_DISABLES, klFePkg::START_CLOCK,
      klFePkg::INIT_CHANNELS, klFePkg::BURST_CTR_RH, klFePkg::COND_STEP, klFePkg::CLR_RESET,
      klFePkg::ENABLE_KL, klFePkg::EBUS_LOAD, klFePkg::WRITE_MBOX};
    for (i = 0; i < 17; i++) begin
      // Six control functions leave the EBUS alone
      expectOp(tbl[i], (tbl[i] == klFePkg::WRITE_MBOX) ? 36'o120 : 36'd0,
        !(tbl[i] inside {klFePkg::CLR_RUN, klFePkg::STOP_CLOCK, klFePkg::SET_RESET,
        klFePkg::START_CLOCK, klFePkg::COND_STEP, klFePkg::CLR_RESET}));
    end
  endtask

  // cw[85] holds KL bit 0
  task automatic expectCram(input logic [15:0] adr, input logic [85:0] cw);
    expectOp(klFePkg::CRAM_DIAG_ADR_RH, 36'(adr[4:0]) << 30, 1'b1);
    expectOp(klFePkg::CRAM_DIAG_ADR_LH, 36'(adr[10:5]) << 30, 1'b1);
    expectOp(klFePkg::CRAM_WRITE_60_79, 36'(cw[25:6]) << 8, 1'b1);
    expectOp(klFePkg::CRAM_WRITE_40_59, 36'(cw[45:26]) << 8, 1'b1);
    expectOp(klFePkg::CRAM_WRITE_20_39, 36'(cw[65:46]) << 8, 1'b1);
    expectOp(klFePkg::CRAM_WRITE_00_19, 36'(cw[85:66]) << 8, 1'b1);
    expectOp(klFePkg::CRAM_WRITE_80_85, 36'(cw[5:0]) << 30, 1'b1);
  endtask

  task automatic buildLoadFile();
    int          l;
    int          k;
    int          j;
    int          kind;
    int          n;
    logic [15:0] adrField;
    logic [15:0] start;
    logic [15:0] cks;
    logic [15:0] d [6];
    for (l = 0; l < lineCount; l++) begin
      kind = randBits(4);
      if (kind <= 9) begin
        // C line of one to three words, kind 9 gets a bad checksum
        n = 1 + randBits(2) % 3;
        adrField = randBits(1) ? 16'd0 : 16'(randBits(10) + 1);
        start = (adrField == 16'd0) ? lastAdr : adrField;
        lastAdr = start + 16'(n);
        fieldQ.push_back(16'(6 * n));
        fieldQ.push_back(adrField);
        cks = 16'(6 * n) + adrField;
        for (k = 0; k < n; k++) begin
          for (j = 0; j < 6; j++) begin
            d[j] = 16'(randBits(16));
            fieldQ.push_back(d[j]);
            cks += d[j];
          end
          expectCram(start + 16'(k), {d[4], d[3], d[2], d[1], d[0], d[5][5:0]});
        end
        cks = -cks + ((kind == 9) ? 16'd1 : 16'd0);
        fieldQ.push_back(cks);
        lineBad.push_back(kind == 9);
        putLine(7'h43);
      end else if (kind <= 13) begin
        // D, Z and comment lines, no bus traffic
        for (j = 0; j < 3; j++) fieldQ.push_back(16'(randBits(16)));
        lineBad.push_back(1'b0);
        putLine((kind <= 11) ? 7'h44 : (kind == 12) ? 7'h5a : 7'h3b);
      end else begin
        // EOF line clears the remembered address
        for (j = 0; j < 3; j++) fieldQ.push_back(16'd0);
        lastAdr = 16'd0;
        lineBad.push_back(1'b0);
        putLine(7'h43);
      end
    end
  endtask

  ////////////////////////////////////////
  // Drive and monitor
  ////////////////////////////////////////

  // Entered 2 ns after a rising edge
  task automatic sendChar(input logic [6:0] c);
    while (charReady !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    charValid = 1'b1;
    charData = c;
    @(posedge clk);
    #2;
    charValid = 1'b0;
  endtask

  // Values read here are those of the cycle before the edge
  always @(posedge clk) begin : busMonitor
    klFePkg::diagFuncE f;
    logic [35:0]       d;
    bit                w;
    if (cksumError === 1'b1) cksumSeen++;
    if (diagStrobe === 1'b1 && !strobePrev) begin
      opsSeen++;
      if (expFunc.size() == 0) begin
        errCnt[curTest]++;
        $display("Unexpected bus operation at %0t with function %o", $time, diagFunc);
      end else begin
        f = expFunc.pop_front();
        d = expData.pop_front();
        w = expDrv.pop_front();
        chkCnt[curTest] += 3;
        assert (diagFunc == f) else begin
          errCnt[curTest]++;
          $display("ERR %0t diagFunc exp %o got %o", $time, f, diagFunc);
        end
        assert (ebusData == d) else begin
          errCnt[curTest]++;
          $display("ERR %0t ebusData exp %o got %o", $time, d, ebusData);
        end
        assert (ebusDriving == w) else begin
          errCnt[curTest]++;
          $display("ERR %0t ebusDriving exp %0d got %0d", $time, w, ebusDriving);
        end
      end
    end
    strobePrev = (diagStrobe === 1'b1);
  end

  task automatic reportTest(input int t, input string name);
    $display("test %s: %0d checks, %0d errors", name, chkCnt[t], errCnt[t]);
  endtask

  initial begin : stimulus
    int l;
    int c;
    int prevEnd;
    int badCount;
    int errTotal;
    rstN = 1'b0;
    charValid = 1'b0;
    charData = '0;
    expectResetTable();
    buildLoadFile();
    genDone = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    // Reset table must be through before characters are taken
    while (charReady !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    chkCnt[0]++;
    assert (opsSeen == 17) else begin
      errCnt[0]++;
      $display("ERR %0t reset operations exp 17 got %0d", $time, opsSeen);
    end
    reportTest(0, "resetTable");
    curTest = 1;
    prevEnd = 0;
    badCount = 0;
    for (l = 0; l < lineEnds.size(); l++) begin
      for (c = prevEnd; c < lineEnds[l]; c++) sendChar(chars[c]);
      prevEnd = lineEnds[l];
      // Strobe follows LF by two cycles
      repeat (3) @(posedge clk);
      #2;
      if (lineBad[l]) badCount++;
      chkCnt[2]++;
      assert (cksumSeen == badCount) else begin
        errCnt[2]++;
        $display("ERR %0t cksumError pulses after line %0d exp %0d got %0d",
          $time, l, badCount, cksumSeen);
      end
    end
    while (expFunc.size() != 0) @(posedge clk);
    // Quiet stretch shows up any extra operation
    repeat (30) @(posedge clk);
    #2;
    reportTest(1, "cramLoad");
    reportTest(2, "checksum");
    errTotal = errCnt[0] + errCnt[1] + errCnt[2];
    $display("tests 3, checks %0d, errors %0d", chkCnt[0] + chkCnt[1] + chkCnt[2], errTotal);
    if (errTotal == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget of 100 cycles per character plus the reset table
  initial begin : watchdog
    int limit;
    wait (genDone);
    limit = chars.size() * 100 + 300;
    repeat (limit) @(posedge clk);
    $display("Run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: bench/klFrontEnd_assert.sv
// klFrontEnd_assert: diagnostic bus timing and character handshake checks for the front end
`timescale 1ns/1ns

module klFrontEnd_assert (
  input logic                         clk,
  input logic                         rstN,
  input logic                         diagStrobe,
  input logic                         ebusDriving,
  input logic                         charReady,
  input klFePkg::diagFuncE            diagFunc,
  input logic [klFePkg::EBUS_W-1:0]   ebusData
);

  logic [3:0] hiCnt;
  logic [3:0] loCnt;
  logic       seenOp;
  logic       cramFunc;

  // C-RAM address and data writes
  assign cramFunc = diagFunc inside {klFePkg::CRAM_DIAG_ADR_RH, klFePkg::CRAM_DIAG_ADR_LH,
    klFePkg::CRAM_WRITE_00_19, klFePkg::CRAM_WRITE_20_39, klFePkg::CRAM_WRITE_40_59,
    klFePkg::CRAM_WRITE_60_79, klFePkg::CRAM_WRITE_80_85};

  // Strobe high and low run lengths
  always_ff @(posedge clk) begin
    if (!rstN) begin
      hiCnt <= '0;
      loCnt <= '0;
      seenOp <= 1'b0;
    end else if (diagStrobe) begin
      hiCnt <= hiCnt + 1'b1;
      loCnt <= '0;
      seenOp <= 1'b1;
    end else begin
      hiCnt <= '0;
      // Saturate over long idle stretches
      loCnt <= (loCnt == 4'hf) ? loCnt : loCnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Bus properties
  ////////////////////////////////////////

  strobeWidth: assert property (@(posedge clk) disable iff (!rstN)
    $fell(diagStrobe) |-> hiCnt == klFePkg::DIAG_HOLD)
    else $error("diagStrobe pulse is not 9 cycles wide");

  // First operation after reset has no gap before it
  strobeGap: assert property (@(posedge clk) disable iff (!rstN)
    $rose(diagStrobe) && seenOp |-> loCnt >= klFePkg::DIAG_GAP)
    else $error("gap between diagnostic operations is shorter than 4 cycles");

  ebusIdle: assert property (@(posedge clk) disable iff (!rstN)
    !ebusDriving |-> ebusData == '0)
    else $error("ebusData is not zero while the EBUS is released");

  readyDuringCram: assert property (@(posedge clk) disable iff (!rstN)
    diagStrobe && cramFunc |-> !charReady)
    else $error("charReady is high during a C-RAM bus operation");

endmodule

bind klFrontEnd klFrontEnd_assert i_assert (
  .clk(clk), .rstN(rstN), .diagStrobe(diagStrobe), .ebusDriving(ebusDriving),
  .charReady(charReady), .diagFunc(diagFunc), .ebusData(ebusData)
);

// File: hdl/klFrontEnd.sv
// klFrontEnd: KL10 front-end loader, master reset then C-RAM load over the diagnostic bus
`timescale 1ns/1ns

module klFrontEnd (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         charValid,
  input  logic [klFePkg::CHAR_W-1:0]   charData,
  output logic                         charReady,
  output klFePkg::diagFuncE            diagFunc,
  output logic                         diagStrobe,
  output logic [klFePkg::EBUS_W-1:0]   ebusData,
  output logic                         ebusDriving,
  output logic                         cksumError
);

  // Decoder to parser
  logic                            wordValid;
  logic [klFePkg::FIELD_W-1:0]     fieldWord;
  logic                            lineEnd;
  logic [klFePkg::CHAR_W-1:0]      recType;

  // Parser to writer
  logic                            dataValid;
  logic [klFePkg::FIELD_W-1:0]     dataWord;
  logic [2:0]                      wordIndex;
  logic [klFePkg::CRAM_ADR_W-1:0]  cramAdr;

  // Bus requests
  logic                            seqReqValid;
  klFePkg::diagFuncE               seqReqFunc;
  logic [klFePkg::EBUS_W-1:0]      seqReqData;
  logic                            seqOpDone;
  logic                            resetDone;
  logic                            cramReqValid;
  klFePkg::diagFuncE               cramReqFunc;
  logic [klFePkg::EBUS_W-1:0]      cramReqData;
  logic                            cramOpDone;

  ////////////////////////////////////////
  // Load file path
  ////////////////////////////////////////

  sixbitWordDecoder i_decoder (
    .clk(clk), .rstN(rstN), .charValid(charValid), .charData(charData),
    .wordValid(wordValid), .fieldWord(fieldWord), .lineEnd(lineEnd), .recType(recType)
  );

  loadRecordParser i_parser (
    .clk(clk), .rstN(rstN), .wordValid(wordValid), .fieldWord(fieldWord),
    .lineEnd(lineEnd), .recType(recType), .dataValid(dataValid), .dataWord(dataWord),
    .wordIndex(wordIndex), .cramAdr(cramAdr), .cksumError(cksumError)
  );

  // charReady comes out of the writer
  cramWriter i_writer (
    .clk(clk), .rstN(rstN), .dataValid(dataValid), .dataWord(dataWord),
    .wordIndex(wordIndex), .cramAdr(cramAdr), .opDone(cramOpDone),
    .resetDone(resetDone), .wordPending(wordValid), .reqValid(cramReqValid),
    .reqFunc(cramReqFunc), .reqData(cramReqData), .busy(), .charReady(charReady)
  );

  ////////////////////////////////////////
  // Diagnostic bus
  ////////////////////////////////////////

  resetSequencer i_resetSeq (
    .clk(clk), .rstN(rstN), .opDone(seqOpDone), .reqValid(seqReqValid),
    .reqFunc(seqReqFunc), .reqData(seqReqData), .resetDone(resetDone)
  );

  // Reset table wins over C-RAM writes
  diagBusDriver i_busDriver (
    .clk(clk), .rstN(rstN),
    .reqValid0(seqReqValid), .reqFunc0(seqReqFunc), .reqData0(seqReqData),
    .reqValid1(cramReqValid), .reqFunc1(cramReqFunc), .reqData1(cramReqData),
    .opDone0(seqOpDone), .opDone1(cramOpDone), .diagFunc(diagFunc),
    .diagStrobe(diagStrobe), .ebusData(ebusData), .ebusDriving(ebusDriving)
  );

endmodule

// File: hdl/diagBusDriver.sv
// diagBusDriver: arbitrates two requesters and times one diagnostic bus operation
`timescale 1ns/1ns

module diagBusDriver (
  input  logic                         clk,
  input  logic                         rstN,
  // Requester 0 has priority
  input  logic                         reqValid0,
  input  klFePkg::diagFuncE            reqFunc0,
  input  logic [klFePkg::EBUS_W-1:0]   reqData0,
  input  logic                         reqValid1,
  input  klFePkg::diagFuncE            reqFunc1,
  input  logic [klFePkg::EBUS_W-1:0]   reqData1,
  output logic                         opDone0,
  output logic                         opDone1,
  output klFePkg::diagFuncE            diagFunc,
  output logic                         diagStrobe,
  output logic [klFePkg::EBUS_W-1:0]   ebusData,
  output logic                         ebusDriving
);

  logic                                    active;
  logic                                    owner;
  logic [$clog2(klFePkg::OP_CYCLES)-1:0]   phase;
  logic                                    lastCycle;
  logic                                    start;
  klFePkg::diagFuncE                       winFunc;
  logic [klFePkg::EBUS_W-1:0]              winData;
  logic                                    winWrite;

  always_comb begin
    winFunc = reqValid0 ? reqFunc0 : reqFunc1;
    winData = reqValid0 ? reqData0 : reqData1;
    // Write functions put data on the EBUS
    winWrite = (winFunc >= klFePkg::FIRST_WRITE_FUNC);
    start = !active && (reqValid0 || reqValid1);
    // Done one cycle early, next request is taken in the last gap cycle
    lastCycle = active && (phase == klFePkg::DIAG_HOLD + klFePkg::DIAG_GAP - 2);
  end

  assign opDone0 = lastCycle && !owner;
  assign opDone1 = lastCycle && owner;

  ////////////////////////////////////////
  // Hold and gap phases
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      active <= 1'b0;
      owner <= 1'b0;
      phase <= '0;
      diagStrobe <= 1'b0;
      ebusDriving <= 1'b0;
      ebusData <= '0;
    end else if (start) begin
      active <= 1'b1;
      owner <= !reqValid0;
      phase <= '0;
      diagStrobe <= 1'b1;
      ebusDriving <= winWrite;
      ebusData <= winWrite ? winData : '0;
    end else if (active) begin
      phase <= phase + 1'b1;
      // End of hold, bus released with the strobe
      if (phase == klFePkg::DIAG_HOLD - 1) begin
        diagStrobe <= 1'b0;
        ebusDriving <= 1'b0;
        ebusData <= '0;
      end
      if (lastCycle) begin
        active <= 1'b0;
      end
    end
  end

  // Function code held until the next operation
  always_ff @(posedge clk) begin
    if (start) begin
      diagFunc <= winFunc;
    end
  end

endmodule

// File: hdl/resetSequencer.sv
// resetSequencer: runs the KL10 master-reset table of diagnostic functions after reset
`timescale 1ns/1ns

module resetSequencer (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         opDone,
  output logic                         reqValid,
  output klFePkg::diagFuncE            reqFunc,
  output logic [klFePkg::EBUS_W-1:0]   reqData,
  output logic                         resetDone
);

  logic [$clog2(klFePkg::RESET_STEPS)-1:0] idx;

  // Request stays up until the table is through
  assign reqValid = !resetDone;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      idx <= '0;
      resetDone <= 1'b0;
    end else if (opDone && !resetDone) begin
      if (idx == klFePkg::RESET_STEPS - 1) begin
        resetDone <= 1'b1;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Master-reset table
  ////////////////////////////////////////

  always_comb begin
    case (idx)
      5'd0:  reqFunc = klFePkg::CLR_RUN;
      // First phase
      5'd1:  reqFunc = klFePkg::CLK_SRC_RATE;
      5'd2:  reqFunc = klFePkg::STOP_CLOCK;
      5'd3:  reqFunc = klFePkg::SET_RESET;
      5'd4:  reqFunc = klFePkg::RESET_PAR_REGS;
      5'd5:  reqFunc = klFePkg::MBOXDIS_PARCHK_ERRSTOP;
      5'd6:  reqFunc = klFePkg::BURST_CTR_RH;
      5'd7:  reqFunc = klFePkg::BURST_CTR_LH;
      5'd8:  reqFunc = klFePkg::SET_EBOX_CLK_DISABLES;
      5'd9:  reqFunc = klFePkg::START_CLOCK;
      5'd10: reqFunc = klFePkg::INIT_CHANNELS;
      5'd11: reqFunc = klFePkg::BURST_CTR_RH;
      // Second phase
      5'd12: reqFunc = klFePkg::COND_STEP;
      5'd13: reqFunc = klFePkg::CLR_RESET;
      5'd14: reqFunc = klFePkg::ENABLE_KL;
      5'd15: reqFunc = klFePkg::EBUS_LOAD;
      default: reqFunc = klFePkg::WRITE_MBOX;
    endcase
    // All data zero except the M-box write
    reqData = (reqFunc == klFePkg::WRITE_MBOX) ? klFePkg::MBOX_WRITE_DATA : '0;
  end

endmodule

// File: hdl/cramWriter.sv
// cramWriter: assembles one C-RAM word and issues its seven diagnostic writes
`timescale 1ns/1ns

module cramWriter (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             dataValid,
  input  logic [klFePkg::FIELD_W-1:0]      dataWord,
  input  logic [2:0]                       wordIndex,
  input  logic [klFePkg::CRAM_ADR_W-1:0]   cramAdr,
  input  logic                             opDone,
  input  logic                             resetDone,
  input  logic                             wordPending,
  output logic                             reqValid,
  output klFePkg::diagFuncE                reqFunc,
  output logic [klFePkg::EBUS_W-1:0]       reqData,
  output logic                             busy,
  output logic                             charReady
);

  // KL10 numbering, bit 0 is the MSB
  logic [0:klFePkg::CRAM_W-1]      cramWord;
  logic [klFePkg::CRAM_ADR_W-1:0]  adr;
  logic [2:0]                      opIdx;
  logic                            lastWord;

  // Sixth word of a location arriving
  assign lastWord = dataValid && (wordIndex == klFePkg::WORDS_PER_CRAM - 1);

  // Hold off characters while a word is assembled or written
  assign charReady = resetDone && !busy && !wordPending && !lastWord;
  assign reqValid = busy;

  ////////////////////////////////////////
  // Word assembly, load file field order
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (dataValid) begin
      case (wordIndex)
        3'd0: cramWord[64:79] <= dataWord;
        3'd1: cramWord[48:63] <= dataWord;
        3'd2: cramWord[32:47] <= dataWord;
        3'd3: cramWord[16:31] <= dataWord;
        3'd4: cramWord[0:15] <= dataWord;
        // CALL and DISP, low six bits only
        default: cramWord[80:85] <= dataWord[5:0];
      endcase
    end
    if (lastWord) begin
      adr <= cramAdr;
    end
  end

  // Write sequencer, one step per opDone
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy <= 1'b0;
      opIdx <= '0;
    end else if (lastWord) begin
      busy <= 1'b1;
      opIdx <= '0;
    end else if (opDone) begin
      if (opIdx == 3'd6) begin
        busy <= 1'b0;
      end else begin
        opIdx <= opIdx + 1'b1;
      end
    end
  end

  // Address halves first, then data high to low, special field last
  always_comb begin
    case (opIdx)
      3'd0: begin
        reqFunc = klFePkg::CRAM_DIAG_ADR_RH;
        reqData = {1'b0, adr[4:0], 30'd0};
      end
      3'd1: begin
        reqFunc = klFePkg::CRAM_DIAG_ADR_LH;
        reqData = {adr[10:5], 30'd0};
      end
      3'd2: begin
        reqFunc = klFePkg::CRAM_WRITE_60_79;
        reqData = {8'd0, cramWord[60:79], 8'd0};
      end
      3'd3: begin
        reqFunc = klFePkg::CRAM_WRITE_40_59;
        reqData = {8'd0, cramWord[40:59], 8'd0};
      end
      3'd4: begin
        reqFunc = klFePkg::CRAM_WRITE_20_39;
        reqData = {8'd0, cramWord[20:39], 8'd0};
      end
      3'd5: begin
        reqFunc = klFePkg::CRAM_WRITE_00_19;
        reqData = {8'd0, cramWord[0:19], 8'd0};
      end
      default: begin
        // EBUS 0-5 land in CRAM 80-85
        reqFunc = klFePkg::CRAM_WRITE_80_85;
        reqData = {cramWord[80:85], 30'd0};
      end
    endcase
  end

endmodule

// File: hdl/loadRecordParser.sv
// loadRecordParser: parses C-RAM load records and emits data words with their address
`timescale 1ns/1ns

module loadRecordParser (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             wordValid,
  input  logic [klFePkg::FIELD_W-1:0]      fieldWord,
  input  logic                             lineEnd,
  input  logic [klFePkg::CHAR_W-1:0]       recType,
  output logic                             dataValid,
  output logic [klFePkg::FIELD_W-1:0]      dataWord,
  output logic [2:0]                       wordIndex,
  output logic [klFePkg::CRAM_ADR_W-1:0]   cramAdr,
  output logic                             cksumError
);

  typedef enum logic [2:0] {
    PS_COUNT,
    PS_ADR,
    PS_DATA,
    PS_CKSUM,
    PS_SKIP
  } parseStateE;

  parseStateE                  state;
  logic [klFePkg::FIELD_W-1:0] wc;
  logic [klFePkg::FIELD_W-1:0] remaining;
  logic [klFePkg::FIELD_W-1:0] curAdr;
  logic [klFePkg::FIELD_W-1:0] lastAdr;
  logic [klFePkg::FIELD_W-1:0] startAdr;
  logic [klFePkg::FIELD_W-1:0] adrStep;
  logic [klFePkg::FIELD_W-1:0] sum;
  logic [klFePkg::FIELD_W-1:0] sumNext;
  logic [2:0]                  idx;
  logic                        isCram;

  always_comb begin
    // 'C' lines only
    isCram = (recType == 7'h43);
    // Running line sum incl. this word
    sumNext = sum + fieldWord;
    // Zero address continues where the last line stopped
    startAdr = (fieldWord == '0) ? lastAdr : fieldWord;
    adrStep = wc / klFePkg::FIELD_W'(klFePkg::WORDS_PER_CRAM);
  end

  ////////////////////////////////////////
  // Record FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= PS_COUNT;
      wc <= '0;
      remaining <= '0;
      curAdr <= '0;
      lastAdr <= '0;
      sum <= '0;
      idx <= '0;
      dataValid <= 1'b0;
      cksumError <= 1'b0;
    end else begin
      dataValid <= 1'b0;
      cksumError <= 1'b0;
      if (wordValid) begin
        sum <= sumNext;
        case (state)
          PS_COUNT: begin
            wc <= fieldWord;
            remaining <= fieldWord;
            // D, Z and comment lines run out to their LF
            state <= isCram ? PS_ADR : PS_SKIP;
          end
          PS_ADR: begin
            if (wc == '0 && fieldWord == '0) begin
              // EOF line
              lastAdr <= '0;
              state <= PS_SKIP;
            end else begin
              curAdr <= startAdr;
              lastAdr <= startAdr + adrStep;
              idx <= '0;
              state <= (wc == '0) ? PS_CKSUM : PS_DATA;
            end
          end
          PS_DATA: begin
            dataValid <= 1'b1;
            remaining <= remaining - 1'b1;
            // Next C-RAM location after each group of six
            if (idx == klFePkg::WORDS_PER_CRAM - 1) begin
              idx <= '0;
              curAdr <= curAdr + 1'b1;
            end else begin
              idx <= idx + 1'b1;
            end
            if (remaining == 1) begin
              state <= PS_CKSUM;
            end
          end
          PS_CKSUM: state <= PS_SKIP;
          default: state <= PS_SKIP;
        endcase
        // Negated checksum makes the line sum zero
        if (lineEnd) begin
          state <= PS_COUNT;
          sum <= '0;
          cksumError <= isCram && (sumNext != '0);
        end
      end
    end
  end

  // Data word out, one cycle behind wordValid
  always_ff @(posedge clk) begin
    if (wordValid && state == PS_DATA) begin
      dataWord <= fieldWord;
      wordIndex <= idx;
      cramAdr <= curAdr[klFePkg::CRAM_ADR_W-1:0];
    end
  end

endmodule

// File: hdl/sixbitWordDecoder.sv
// sixbitWordDecoder: turns ASCIIized load file characters into 16-bit field words
`timescale 1ns/1ns

module sixbitWordDecoder (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           charValid,
  input  logic [klFePkg::CHAR_W-1:0]     charData,
  output logic                           wordValid,
  output logic [klFePkg::FIELD_W-1:0]    fieldWord,
  output logic                           lineEnd,
  output logic [klFePkg::CHAR_W-1:0]     recType
);

  logic                        lineStart;
  logic [klFePkg::FIELD_W-1:0] acc;
  logic                        isLf;
  logic                        isSep;
  logic                        isSpace;

  // Character classes
  always_comb begin
    isLf = (charData == 7'h0a);
    // Comma, CR or LF close a field
    isSep = isLf || (charData == 7'h0d) || (charData == 7'h2c);
    isSpace = (charData == 7'h20);
  end

  ////////////////////////////////////////
  // Line framing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      lineStart <= 1'b1;
      wordValid <= 1'b0;
      lineEnd <= 1'b0;
    end else begin
      // One-cycle strobe, the cycle after the separator
      wordValid <= charValid && !lineStart && isSep;
      lineEnd <= charValid && !lineStart && isLf;
      if (charValid) begin
        if (lineStart && !isSep) begin
          lineStart <= 1'b0;
        end else if (isLf) begin
          lineStart <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Field accumulator
  ////////////////////////////////////////

  // Both un-ASCIIize cases reduce to the low six bits of a 7-bit char
  always_ff @(posedge clk) begin
    if (charValid) begin
      if (lineStart) begin
        // First char of the line is the record type
        recType <= charData;
        acc <= '0;
      end else if (isSep) begin
        // Empty field gives zero
        fieldWord <= acc;
        acc <= '0;
      end else if (!isSpace) begin
        acc <= {acc[klFePkg::FIELD_W-7:0], charData[5:0]};
      end
    end
  end

endmodule

// File: hdl/klFePkg.sv
// klFePkg: diagnostic function codes, bus timing and field widths shared by the front end
package klFePkg;

  ////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////

  // EBUS data word
  localparam int EBUS_W = 36;
  // PDP-11 word carried by one load file field
  localparam int FIELD_W = 16;
  // C-RAM word, bits 0 to 85 in KL10 numbering
  localparam int CRAM_W = 86;
  localparam int CRAM_ADR_W = 11;
  // Field words per C-RAM word
  localparam int WORDS_PER_CRAM = 6;
  // Load file characters are 7-bit ASCII
  localparam int CHAR_W = 7;

  ////////////////////////////////////////
  // Diagnostic bus timing, in clocks
  ////////////////////////////////////////

  localparam int DIAG_HOLD = 9;
  localparam int DIAG_GAP = 4;
  localparam int OP_CYCLES = DIAG_HOLD + DIAG_GAP;

  // Entries in the master-reset table
  localparam int RESET_STEPS = 17;
  // Data for the closing WRITE_MBOX step
  localparam logic [EBUS_W-1:0] MBOX_WRITE_DATA = 36'o120;
  // Codes from here up put data on the EBUS
  localparam logic [6:0] FIRST_WRITE_FUNC = 7'o040;

  // Diagnostic function codes, octal as in the KL10 prints
  typedef enum logic [6:0] {
    CLR_RUN                = 7'o010,
    CLK_SRC_RATE           = 7'o044,
    STOP_CLOCK             = 7'o000,
    SET_RESET              = 7'o007,
    RESET_PAR_REGS         = 7'o046,
    MBOXDIS_PARCHK_ERRSTOP = 7'o047,
    BURST_CTR_RH           = 7'o042,
    BURST_CTR_LH           = 7'o043,
    SET_EBOX_CLK_DISABLES  = 7'o045,
    START_CLOCK            = 7'o001,
    INIT_CHANNELS          = 7'o070,
    COND_STEP              = 7'o004,
    CLR_RESET              = 7'o006,
    ENABLE_KL              = 7'o067,
    EBUS_LOAD              = 7'o076,
    WRITE_MBOX             = 7'o071,
    // C-RAM diagnostic address and data writes
    CRAM_DIAG_ADR_RH       = 7'o051,
    CRAM_DIAG_ADR_LH       = 7'o052,
    CRAM_WRITE_00_19       = 7'o053,
    CRAM_WRITE_20_39       = 7'o054,
    CRAM_WRITE_40_59       = 7'o055,
    CRAM_WRITE_60_79       = 7'o056,
    CRAM_WRITE_80_85       = 7'o057
  } diagFuncE;

endpackage
